// ==== branch_predictor_top.f ====
logic/bp_config_pkg.sv
logic/rv_isa_pkg.sv
logic/branch_decode.sv
logic/gshare.sv
logic/history_queue.sv
logic/branch_resolve.sv
logic/branch_predictor_top.sv
verif/branch_predictor_tb.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - logic/bp_config_pkg.sv
  - logic/rv_isa_pkg.sv
  - logic/branch_decode.sv
  - logic/gshare.sv
  - logic/history_queue.sv
  - logic/branch_resolve.sv
  - logic/branch_predictor_top.sv
  - target: test
    files:
      - verif/branch_predictor_tb.sv

// ==== verif/branch_predictor_tb.sv ====
// directed tests against a cycle model of table, history and queue
// inputs change on the falling edge, outputs are sampled 1 ns later
`timescale 1ns/1ps

module branch_predictor_tb
	import bp_config_pkg::*;
();

	localparam logic [31:0] beq_word = 32'h00b50463; // beq a0, a1, 8
	localparam logic [31:0] rsvd_word = 32'h00b52463; // funct3 2, reserved
	localparam logic [31:0] addi_word = 32'h00150513; // not a branch

	logic clock, reset, fetch_valid, resolve_valid, resolve_taken;
	logic [31:0] fetch_pc, fetch_instr;
	logic prediction_valid, prediction_taken, mispredict, queue_full;
	logic [5:0] history;

	bit m_pht [pht_entries]; // model state
	logic [bh_size-1:0] m_hist;
	logic [bh_size-1:0] q_hist [$];
	logic [31:0] q_pc [$];
	bit q_taken [$];
	logic [15:0] lfsr_state = 16'd46;
	int checks = 0;
	int errors = 0;
	logic seen_pv, seen_pt, seen_mis; // dut outputs of the last cycle

	branch_predictor_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic bit lfsr_bit();
		bit out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) lfsr_state = lfsr_state ^ 16'hb400; // galois taps 16,14,13,11
		return out;
	endfunction

	function automatic logic [31:0] random_pc();
		logic [31:0] pc;
		pc = '0; // word aligned
		for (int i = 2; i < 32; i++) pc[i] = lfsr_bit();
		return pc;
	endfunction

	task automatic expect_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		fetch_valid = 1'b0;
		resolve_valid = 1'b0;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		foreach (m_pht[i]) m_pht[i] = 1'b0; // all not taken
		m_hist = '0;
		q_hist.delete();
		q_pc.delete();
		q_taken.delete();
	endtask

	// one clock of stimulus, checked against the model before and after the edge
	task automatic cycle(input logic fv, input logic [31:0] pc, input logic [31:0] instr,
			input logic rv, input logic rt);
		bit is_br, hit, mis, pv, pt;
		logic [bh_size-1:0] idx;
		@(negedge clock);
		fetch_valid = fv;
		fetch_pc = pc;
		fetch_instr = instr;
		resolve_valid = rv;
		resolve_taken = rt;
		#1;
		is_br = fv && instr[6:0] == 7'b1100011 && instr[14:12] != 3'd2 && instr[14:12] != 3'd3;
		hit = rv && q_hist.size() > 0; // empty queue ignores the resolve
		mis = hit && (rt != q_taken[0]);
		pv = is_br && q_hist.size() < obq_depth && !mis;
		idx = m_hist ^ pc[pc_lsb +: bh_size];
		pt = pv && m_pht[idx];
		seen_pv = prediction_valid;
		seen_pt = prediction_taken;
		seen_mis = mispredict;
		expect_eq(prediction_valid, pv, "prediction_valid");
		expect_eq(prediction_taken, pt, "prediction_taken");
		expect_eq(mispredict, mis, "mispredict");
		expect_eq(queue_full, q_hist.size() == obq_depth, "queue_full");
		expect_eq(history, m_hist, "history before edge");
		if (mis) begin
			idx = q_hist[0] ^ q_pc[0][pc_lsb +: bh_size];
			m_pht[idx] = !m_pht[idx]; // flip the entry that mispredicted
			m_hist = {q_hist[0][bh_size-2:0], rt};
			q_hist.delete();
			q_pc.delete();
			q_taken.delete();
		end else begin
			if (hit) begin
				void'(q_hist.pop_front());
				void'(q_pc.pop_front());
				void'(q_taken.pop_front());
			end
			if (pv) begin
				q_hist.push_back(m_hist); // snapshot before the shift
				q_pc.push_back(pc);
				q_taken.push_back(pt);
				m_hist = {m_hist[bh_size-2:0], pt};
			end
		end
		@(posedge clock);
		#1;
		expect_eq(history, m_hist, "history after edge");
	endtask

	// resolve every queued branch in its predicted direction
	task automatic drain();
		int guard;
		guard = 0;
		while (q_hist.size() > 0 && guard < 2 * obq_depth) begin
			cycle(1'b0, 32'h0, addi_word, 1'b1, q_taken[0]);
			guard++;
		end
		expect_eq(queue_full, 0, "queue_full after drain");
	endtask

	task automatic wait_queue_full(input logic level);
		int n;
		n = 0;
		while (queue_full !== level && n < 10) begin
			@(negedge clock);
			n++;
		end
		if (queue_full !== level) begin
			$display("queue_full did not reach %0b within 10 cycles", level);
			$display("Checks failed");
			$finish;
		end
	endtask

	task automatic report(input string name, input int errors_before);
		$display("%s done, %0d new failures", name, errors - errors_before);
	endtask

	task automatic test_after_reset();
		int e0;
		logic [31:0] pc;
		e0 = errors;
		apply_reset();
		expect_eq(history, 0, "history after reset");
		pc = random_pc();
		cycle(1'b1, pc, beq_word, 1'b0, 1'b0);
		expect_eq({seen_pv, seen_pt}, 2'b10, "first branch not taken");
		cycle(1'b1, random_pc(), addi_word, 1'b0, 1'b0); // non-branch
		expect_eq(seen_pv, 0, "prediction on addi");
		cycle(1'b0, pc, beq_word, 1'b0, 1'b0); // invalid fetch
		cycle(1'b1, pc, rsvd_word, 1'b0, 1'b0); // reserved funct3
		expect_eq(seen_pv, 0, "prediction on reserved funct3");
		drain();
		report("test_after_reset", e0);
	endtask

	task automatic test_history_shift();
		int e0;
		logic [31:0] pc;
		logic [bh_size-1:0] hot;
		e0 = errors;
		drain();
		// a miss turns one entry taken and leaves a one in the history
		pc = random_pc();
		hot = m_hist ^ pc[pc_lsb +: bh_size];
		cycle(1'b1, pc, beq_word, 1'b0, 1'b0);
		cycle(1'b0, 32'h0, addi_word, 1'b1, !q_taken[0]);
		// non-branch and invalid fetches must not move that one
		cycle(1'b1, random_pc(), addi_word, 1'b0, 1'b0);
		cycle(1'b0, random_pc(), beq_word, 1'b0, 1'b0);
		for (int i = 0; i < obq_depth; i++) begin
			pc = random_pc();
			if (i % 2 == 1) begin
				pc[pc_lsb +: bh_size] = m_hist ^ hot; // lands on the taken entry
			end
			cycle(1'b1, pc, beq_word, 1'b0, 1'b0);
			if (i % 2 == 1) begin
				expect_eq(seen_pt, 1, "branch on the flipped entry");
			end
		end
		drain();
		report("test_history_shift", e0);
	endtask

	task automatic test_mispredict();
		int e0;
		logic [31:0] p, q;
		logic [bh_size-1:0] f;
		e0 = errors;
		apply_reset(); // known table and zero history
		p = random_pc();
		f = p[pc_lsb +: bh_size];
		cycle(1'b1, p, beq_word, 1'b0, 1'b0);
		expect_eq(seen_pt, 0, "fresh branch direction");
		cycle(1'b0, 32'h0, addi_word, 1'b1, 1'b1);
		expect_eq(seen_mis, 1, "mispredict on taken");
		expect_eq(history, 6'b000001, "history after rollback");
		// shift zeros back in, steering clear of the flipped entry
		repeat (bh_size) begin
			q = random_pc();
			q[pc_lsb +: bh_size] = f ^ history ^ 6'd1;
			cycle(1'b1, q, beq_word, 1'b1, 1'b0);
		end
		expect_eq(history, 0, "history back to zero");
		drain();
		cycle(1'b1, p, beq_word, 1'b0, 1'b0);
		expect_eq(seen_pt, 1, "replayed branch taken");
		drain();
		report("test_mispredict", e0);
	endtask

	task automatic test_queue_full();
		int e0;
		e0 = errors;
		drain();
		repeat (obq_depth) cycle(1'b1, random_pc(), beq_word, 1'b0, 1'b0);
		wait_queue_full(1'b1);
		cycle(1'b1, random_pc(), beq_word, 1'b0, 1'b0); // fifth branch
		expect_eq(seen_pv, 0, "prediction while full");
		cycle(1'b0, 32'h0, addi_word, 1'b1, q_taken[0]);
		expect_eq(seen_mis, 0, "correct resolve");
		expect_eq(queue_full, 0, "queue_full after pop");
		drain();
		report("test_queue_full", e0);
	endtask

	task automatic test_flush();
		int e0;
		e0 = errors;
		drain();
		repeat (3) cycle(1'b1, random_pc(), beq_word, 1'b0, 1'b0);
		cycle(1'b1, random_pc(), beq_word, 1'b1, !q_taken[0]); // fetch in miss cycle
		expect_eq({seen_mis, seen_pv}, 2'b10, "mispredict blocks fetch");
		cycle(1'b0, 32'h0, addi_word, 1'b1, 1'b1); // queue now empty
		expect_eq(seen_mis, 0, "resolve on empty queue");
		cycle(1'b1, random_pc(), beq_word, 1'b0, 1'b0);
		expect_eq(seen_pv, 1, "prediction after flush");
		drain();
		report("test_flush", e0);
	endtask

	initial begin
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_instr = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		test_after_reset();
		test_history_shift();
		test_mispredict();
		test_queue_full();
		test_flush();
		$display("%0d checks, %0d failures", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== logic/branch_predictor_top.sv ====
// fetch-side branch prediction, direction only and no target
// fetch and resolve are plain one-cycle levels, queue_full is the only stall hint
`timescale 1ns/1ps

module branch_predictor_top (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input logic [31:0] fetch_pc,
	input logic [31:0] fetch_instr,
	input logic resolve_valid,
	input logic resolve_taken,
	output logic prediction_valid,
	output logic prediction_taken,
	output logic mispredict,
	output logic queue_full,
	output logic [5:0] history
);

	logic is_branch;

	logic head_valid;
	logic [5:0] head_history;
	logic [31:0] head_pc;
	logic head_taken;

	logic pop;
	logic flush;
	logic rollback_en;
	logic [5:0] rollback_history;
	logic [31:0] rollback_pc;
	logic rollback_taken;

	branch_decode u_decode (
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.is_branch (is_branch)
	);

	gshare u_gshare (
		.clock (clock),
		.reset (reset),
		.is_branch (is_branch),
		.queue_full (queue_full),
		.fetch_pc (fetch_pc),
		.rollback_en (rollback_en),
		.rollback_history (rollback_history),
		.rollback_pc (rollback_pc),
		.rollback_taken (rollback_taken),
		.prediction_valid (prediction_valid),
		.prediction_taken (prediction_taken),
		.history (history)
	);

	// every prediction is pushed with the history from before its own shift
	history_queue u_queue (
		.clock (clock),
		.reset (reset),
		.push (prediction_valid),
		.push_history (history),
		.push_pc (fetch_pc),
		.push_taken (prediction_taken),
		.pop (pop),
		.flush (flush),
		.head_valid (head_valid),
		.head_history (head_history),
		.head_pc (head_pc),
		.head_taken (head_taken),
		.full (queue_full)
	);

	branch_resolve u_resolve (
		.resolve_valid (resolve_valid),
		.resolve_taken (resolve_taken),
		.head_valid (head_valid),
		.head_history (head_history),
		.head_pc (head_pc),
		.head_taken (head_taken),
		.pop (pop),
		.flush (flush),
		.mispredict (mispredict),
		.rollback_en (rollback_en),
		.rollback_history (rollback_history),
		.rollback_pc (rollback_pc),
		.rollback_taken (rollback_taken)
	);

endmodule

// ==== logic/branch_resolve.sv ====
// combinational, expects outcomes from execute in program order
// a resolve with an empty queue is dropped without any effect
`timescale 1ns/1ps

module branch_resolve
	import bp_config_pkg::*;
(
	input logic resolve_valid,
	input logic resolve_taken,
	input logic head_valid,
	input logic [bh_size-1:0] head_history,
	input logic [31:0] head_pc,
	input logic head_taken,
	output logic pop,
	output logic flush,
	output logic mispredict,
	output logic rollback_en,
	output logic [bh_size-1:0] rollback_history,
	output logic [31:0] rollback_pc,
	output logic rollback_taken
);

	logic resolve_hit; // resolve that has a matching queue entry
	logic wrong_dir;

	assign resolve_hit = resolve_valid & head_valid;
	assign wrong_dir = (resolve_taken != head_taken);

	// the head retires on every resolve, flush covers the miss case anyway
	assign pop = resolve_hit;

	assign mispredict = resolve_hit & wrong_dir;

	// everything younger than the head was fetched down the wrong path
	assign flush = mispredict;
	assign rollback_en = mispredict;

	// snapshot before the bad shift plus the pc gives the entry to flip
	assign rollback_history = head_history;
	assign rollback_pc = head_pc;
	assign rollback_taken = resolve_taken; // real outcome goes into history

endmodule

// ==== logic/history_queue.sv ====
// in-order circular buffer of per-branch snapshots, head is the oldest branch
// flush beats push and pop, push is dropped when full and no pop frees a slot
`timescale 1ns/1ps

module history_queue
	import bp_config_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic push,
	input logic [bh_size-1:0] push_history,
	input logic [31:0] push_pc,
	input logic push_taken,
	input logic pop,
	input logic flush,
	output logic head_valid,
	output logic [bh_size-1:0] head_history,
	output logic [31:0] head_pc,
	output logic head_taken,
	output logic full
);

	// payload storage
	logic [bh_size-1:0] history_mem [obq_depth];
	logic [31:0] pc_mem [obq_depth];
	logic taken_mem [obq_depth];

	logic [obq_ptr_bits-1:0] rd_ptr;
	logic [obq_ptr_bits-1:0] wr_ptr;
	logic [obq_ptr_bits:0] count; // one extra bit to tell full from empty

	logic do_push;
	logic do_pop;

	assign head_valid = (count != '0);
	assign full = count[obq_ptr_bits]; // set only at count == obq_depth

	assign do_pop = pop & head_valid;
	assign do_push = push & (~full | do_pop);

	// oldest entry straight out of the buffer
	assign head_history = history_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];
	assign head_taken = taken_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push && !flush) begin
			history_mem[wr_ptr] <= push_history;
			pc_mem[wr_ptr] <= push_pc;
			taken_mem[wr_ptr] <= push_taken;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			// a mispredict squashes every younger branch
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at obq_depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

endmodule

// ==== logic/gshare.sv ====
// gshare with a one-bit pattern table, index is history xor pc[pc_lsb +: bh_size]
// prediction is combinational, history shifts on the next edge
// rollback beats a new prediction in the same cycle
`timescale 1ns/1ps

module gshare
	import bp_config_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic is_branch,
	input logic queue_full,
	input logic [31:0] fetch_pc,
	input logic rollback_en,
	input logic [bh_size-1:0] rollback_history,
	input logic [31:0] rollback_pc,
	input logic rollback_taken,
	output logic prediction_valid,
	output logic prediction_taken,
	output logic [bh_size-1:0] history
);

	// 0 : not taken, 1 : taken
	logic [pht_entries-1:0] pht;

	logic [bh_size-1:0] fetch_idx;
	logic [bh_size-1:0] rollback_idx;
	logic [bh_size-1:0] next_history;
	logic predict_en;
	logic table_bit;

	// same hash on both sides so the flip hits the entry that was read
	assign fetch_idx = history ^ fetch_pc[pc_lsb +: bh_size];
	assign rollback_idx = rollback_history ^ rollback_pc[pc_lsb +: bh_size];

	assign table_bit = pht[fetch_idx];

	// no prediction while the queue is full or a mispredict is being repaired
	assign predict_en = is_branch & ~queue_full & ~rollback_en;

	assign prediction_valid = predict_en;
	assign prediction_taken = predict_en & table_bit; // low when nothing is predicted

	always_comb begin
		next_history = history;
		if (rollback_en) begin
			// snapshot was taken before the bad shift, insert the real outcome
			next_history = {rollback_history[bh_size-2:0], rollback_taken};
		end else if (predict_en) begin
			next_history = {history[bh_size-2:0], table_bit}; // speculative
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0; // all not taken
			history <= '0;
		end else begin
			history <= next_history;
			if (rollback_en) begin
				pht[rollback_idx] <= ~pht[rollback_idx]; // one-bit table, flip on miss
			end
		end
	end

endmodule

// ==== logic/branch_decode.sv ====
// purely combinational, looks at one fetched word per cycle
// compressed instructions are not recognised
`timescale 1ns/1ps

module branch_decode
	import rv_isa_pkg::*;
(
	input logic fetch_valid,
	input logic [31:0] fetch_instr,
	output logic is_branch
);

	logic [opcode_msb-opcode_lsb:0] opcode;
	logic [funct3_msb-funct3_lsb:0] funct3;
	logic opcode_match;
	logic funct3_legal;

	assign opcode = fetch_instr[opcode_msb:opcode_lsb];
	assign funct3 = fetch_instr[funct3_msb:funct3_lsb];

	assign opcode_match = (opcode == opcode_branch);

	// beq, bne, blt, bge, bltu, bgeu
	always_comb begin
		case (funct3)
			3'd2,
			3'd3: funct3_legal = 1'b0; // reserved, not a branch
			default: funct3_legal = 1'b1;
		endcase
	end

	// only a valid fetch with a legal encoding counts
	assign is_branch = fetch_valid & opcode_match & funct3_legal;

endmodule

// ==== logic/rv_isa_pkg.sv ====
// rv32 fields needed to spot conditional branches, 32-bit encodings only
package rv_isa_pkg;

	// major opcode of beq/bne/blt/bge/bltu/bgeu
	localparam logic [6:0] opcode_branch = 7'b1100011;

	localparam int opcode_lsb = 0;
	localparam int opcode_msb = 6;

	// funct3 picks the compare, codes 2 and 3 are reserved
	localparam int funct3_lsb = 12;
	localparam int funct3_msb = 14;

endpackage

// ==== logic/bp_config_pkg.sv ====
// geometry of the gshare predictor and its history queue
// obq_depth must be a power of two, since the queue pointers wrap on overflow
package bp_config_pkg;

	// global history length, also the pattern table index width
	localparam int bh_size = 6;
	localparam int pht_entries = 2 ** bh_size; // one bit per entry

	// lowest pc bit in the hash, skips the byte offset
	localparam int pc_lsb = 2;

	// branches that may be in flight between fetch and resolve
	localparam int obq_depth = 4;
	localparam int obq_ptr_bits = $clog2(obq_depth);

endpackage
